// ==== src/neoB1Pkg.sv ====
`default_nettype none

package neoB1Pkg;

	// Palette bus address
	// Upper 8 bits pick the palette, lower 4 bits pick the colour
	typedef logic [11:0] palIndexT;

	// Empty line buffer location, also the background colour
	localparam palIndexT LB_CLEAR = 12'hFFF;

	// Sprite strip serializer
	typedef enum logic
	{
		// Waiting for a strip
		SPR_IDLE,
		// Walking the 8 pixels of the latched strip
		SPR_EMIT
	} sprStateT;

	// Line scan of the palette mux
	typedef enum logic
	{
		// Between lines
		SCAN_IDLE,
		// One pixel read per clock
		SCAN_ACTIVE
	} scanStateT;

endpackage

`default_nettype wire

// ==== src/lineBufferWriteIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface lineBufferWriteIf #(
	parameter int LINE_WIDTH = 320,
	localparam int ADDR_W = $clog2(LINE_WIDTH)
);
	import neoB1Pkg::*;

	// Write request, held stable until accepted
	logic valid;
	// Low only while the banks swap
	logic ready;
	logic [ADDR_W-1:0] addr;
	palIndexT data;

	// Sprite side
	modport source (output valid, output addr, output data, input ready);

	// Line buffer side
	modport sink (input valid, input addr, input data, output ready);

endinterface

`default_nettype wire

// ==== src/spritePixelWriter.sv ====
`timescale 1ns/1ps
`default_nettype none

module spritePixelWriter #(
	parameter int LINE_WIDTH = 320,
	localparam int ADDR_W = $clog2(LINE_WIDTH)
) (
	input wire CLK_6MB,
	input wire nS1H1,
	input wire sprValid,
	output logic sprReady,
	input wire [ADDR_W-1:0] sprX,
	input wire [7:0] sprPal,
	input wire [31:0] sprGfx,
	lineBufferWriteIf.source lbWr
);
	import neoB1Pkg::*;

	sprStateT state;
	// Latched strip
	logic [ADDR_W-1:0] stripX;
	logic [7:0] stripPal;
	logic [31:0] stripGfx;
	// Pixel being looked at, 0 is the lowest nibble
	logic [2:0] pixIdx;
	logic [3:0] pixColour;
	// One extra bit so strips hanging off the right edge can be caught
	logic [ADDR_W:0] pixAddr;
	logic pixInRange;
	logic pixOpaque;
	logic advance;

	assign pixColour = stripGfx[{pixIdx, 2'b00} +: 4];
	assign pixAddr = {1'b0, stripX} + (ADDR_W + 1)'(pixIdx);
	assign pixInRange = pixAddr < (ADDR_W + 1)'(LINE_WIDTH);
	// Colour 0 is see-through
	assign pixOpaque = pixColour != 4'h0;

	// Only opaque, on-screen pixels cost a write
	assign lbWr.valid = (state == SPR_EMIT) && pixOpaque && pixInRange;
	assign lbWr.addr = pixAddr[ADDR_W-1:0];
	assign lbWr.data = {stripPal, pixColour};

	// Skipped pixels move on at once, real writes wait for the buffer
	assign advance = !lbWr.valid || lbWr.ready;
	assign sprReady = (state == SPR_IDLE);

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			state <= SPR_IDLE;
			pixIdx <= '0;
		end
		else
		begin
			case (state)
				SPR_IDLE:
				begin
					if (sprValid)
					begin
						state <= SPR_EMIT;
						pixIdx <= '0;
					end
				end
				SPR_EMIT:
				begin
					if (advance)
					begin
						// Last nibble done, ready for the next strip
						if (pixIdx == 3'd7)
							state <= SPR_IDLE;
						pixIdx <= pixIdx + 3'd1;
					end
				end
				default: state <= SPR_IDLE;
			endcase
		end
	end

	// Strip capture on handshake
	always_ff @(posedge CLK_6MB)
	begin
		if (sprValid && sprReady)
		begin
			stripX <= sprX;
			stripPal <= sprPal;
			stripGfx <= sprGfx;
		end
	end

endmodule

`default_nettype wire

// ==== src/lineBuffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module lineBuffer #(
	parameter int LINE_WIDTH = 320,
	localparam int ADDR_W = $clog2(LINE_WIDTH)
) (
	input wire CLK_6MB,
	input wire nS1H1,
	input wire lineStart,
	lineBufferWriteIf.sink lbWr,
	input wire rdEn,
	input wire [ADDR_W-1:0] rdAddr,
	output neoB1Pkg::palIndexT rdData
);
	import neoB1Pkg::*;

	// Bank being filled, the other one is on screen
	logic bankSel;
	logic wrFire;
	// Read value of each bank at rdAddr
	palIndexT bankRd [2];

	// Writes pause for the swap cycle only
	assign lbWr.ready = !lineStart;
	assign wrFire = lbWr.valid && lbWr.ready;

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
			bankSel <= 1'b0;
		else if (lineStart)
			bankSel <= !bankSel;
	end

	for (genvar b = 0; b < 2; b++)
	begin : genBank
		palIndexT mem [LINE_WIDTH];
		// Locations never written since reset read as clear
		logic [LINE_WIDTH-1:0] loaded;
		logic isWrBank;

		assign isWrBank = (bankSel == b[0]);

		// Fill in the write bank, wipe behind the scan in the read bank
		always_ff @(posedge CLK_6MB)
		begin
			if (isWrBank && wrFire)
				mem[lbWr.addr] <= lbWr.data;
			else if (!isWrBank && rdEn)
				mem[rdAddr] <= LB_CLEAR;
		end

		always_ff @(posedge CLK_6MB or posedge nS1H1)
		begin
			if (nS1H1)
				loaded <= '0;
			else if (isWrBank && wrFire)
				loaded[lbWr.addr] <= 1'b1;
		end

		assign bankRd[b] = loaded[rdAddr] ? mem[rdAddr] : LB_CLEAR;
	end

	// One clock read latency from the display bank
	always_ff @(posedge CLK_6MB)
	begin
		if (rdEn)
			rdData <= bankRd[!bankSel];
	end

endmodule

`default_nettype wire

// ==== src/paletteAddressMux.sv ====
`timescale 1ns/1ps
`default_nettype none

module paletteAddressMux #(
	parameter int LINE_WIDTH = 320,
	localparam int ADDR_W = $clog2(LINE_WIDTH)
) (
	input wire CLK_6MB,
	input wire nS1H1,
	input wire lineStart,
	input wire [7:0] fixData,
	input wire [3:0] fixPal,
	input wire cpuPalSel,
	input wire neoB1Pkg::palIndexT cpuPalAddr,
	output logic rdEn,
	output logic [ADDR_W-1:0] rdAddr,
	input wire neoB1Pkg::palIndexT rdData,
	output neoB1Pkg::palIndexT palAddr
);
	import neoB1Pkg::*;

	scanStateT state;
	logic [ADDR_W-1:0] pixCnt;
	// Stage 1, lines up with rdData
	logic s1Valid;
	logic [7:0] s1FixData;
	logic [3:0] s1FixPal;
	logic s1Odd;
	logic [3:0] fixNibble;
	palIndexT pixResult;
	// Stage 2, the registered pixel
	palIndexT palReg;

	// Pixel counter drives the buffer read directly
	assign rdEn = (state == SCAN_ACTIVE);
	assign rdAddr = pixCnt;

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			state <= SCAN_IDLE;
			pixCnt <= '0;
		end
		else if (lineStart)
		begin
			// New line restarts the scan even mid-line
			state <= SCAN_ACTIVE;
			pixCnt <= '0;
		end
		else if (state == SCAN_ACTIVE)
		begin
			if (pixCnt == ADDR_W'(LINE_WIDTH - 1))
				state <= SCAN_IDLE;
			pixCnt <= pixCnt + 1'b1;
		end
	end

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
			s1Valid <= 1'b0;
		else
			s1Valid <= rdEn;
	end

	// Fix layer sampled with the read request
	always_ff @(posedge CLK_6MB)
	begin
		s1FixData <= fixData;
		s1FixPal <= fixPal;
		s1Odd <= pixCnt[0];
	end

	// Stands in for the half-pixel clock, odd pixels take the high nibble
	assign fixNibble = s1Odd ? s1FixData[7:4] : s1FixData[3:0];
	// Opaque fix wins over sprites
	assign pixResult = (fixNibble != 4'h0) ? {4'h0, s1FixPal, fixNibble} : rdData;

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
			palReg <= LB_CLEAR;
		else if (s1Valid)
			palReg <= pixResult;
		else
			palReg <= LB_CLEAR;
	end

	// CPU palette access beats everything, no register
	assign palAddr = cpuPalSel ? cpuPalAddr : palReg;

endmodule

`default_nettype wire

// ==== src/watchdog.sv ====
`timescale 1ns/1ps
`default_nettype none

module watchdog #(
	parameter int WD_LIMIT = 8192,
	parameter int WD_PULSE = 16,
	localparam int IDLE_W = $clog2(WD_LIMIT + 1),
	localparam int PULSE_W = $clog2(WD_PULSE + 1)
) (
	input wire CLK_6MB,
	input wire nS1H1,
	input wire wdKick,
	output logic nHalt,
	output logic nReset
);

	// Cycles since the last kick
	logic [IDLE_W-1:0] idleCnt;
	// Reset pulse cycles left, non-zero while firing
	logic [PULSE_W-1:0] pulseCnt;
	logic firing;

	assign firing = (pulseCnt != '0);

	always_ff @(posedge CLK_6MB or posedge nS1H1)
	begin
		if (nS1H1)
		begin
			idleCnt <= '0;
			pulseCnt <= '0;
		end
		else if (firing)
		begin
			// Kicks are ignored during the pulse
			pulseCnt <= pulseCnt - 1'b1;
			idleCnt <= '0;
		end
		else if (wdKick)
			idleCnt <= '0;
		else if (idleCnt == IDLE_W'(WD_LIMIT - 1))
		begin
			// Timed out, start the pulse and rearm
			pulseCnt <= PULSE_W'(WD_PULSE);
			idleCnt <= '0;
		end
		else
			idleCnt <= idleCnt + 1'b1;
	end

	// Both lines drop together
	assign nHalt = !firing;
	assign nReset = !firing;

endmodule

`default_nettype wire

// ==== src/neoB1.sv ====
`timescale 1ns/1ps
`default_nettype none

module neoB1 #(
	parameter int LINE_WIDTH = 320,
	parameter int WD_LIMIT = 8192,
	parameter int WD_PULSE = 16,
	localparam int ADDR_W = $clog2(LINE_WIDTH)
) (
	input wire CLK_6MB,
	input wire nS1H1,
	// Sprite strips
	input wire sprValid,
	output logic sprReady,
	input wire [ADDR_W-1:0] sprX,
	input wire [7:0] sprPal,
	input wire [31:0] sprGfx,
	// Line timing and fix layer
	input wire lineStart,
	input wire [7:0] fixData,
	input wire [3:0] fixPal,
	// CPU side
	input wire cpuPalSel,
	input wire neoB1Pkg::palIndexT cpuPalAddr,
	input wire wdKick,
	// Palette bus and system control
	output neoB1Pkg::palIndexT palAddr,
	output logic nHalt,
	output logic nReset
);
	import neoB1Pkg::*;

	// Display read port
	logic rdEn;
	logic [ADDR_W-1:0] rdAddr;
	palIndexT rdData;

	// Sprite writes into the buffer
	lineBufferWriteIf #(.LINE_WIDTH(LINE_WIDTH)) lbWrBus ();

	spritePixelWriter #(.LINE_WIDTH(LINE_WIDTH)) spritePixelWriter_inst (
		.CLK_6MB (CLK_6MB),
		.nS1H1 (nS1H1),
		.sprValid (sprValid),
		.sprReady (sprReady),
		.sprX (sprX),
		.sprPal (sprPal),
		.sprGfx (sprGfx),
		.lbWr (lbWrBus.source)
	);

	lineBuffer #(.LINE_WIDTH(LINE_WIDTH)) lineBuffer_inst (
		.CLK_6MB (CLK_6MB),
		.nS1H1 (nS1H1),
		.lineStart (lineStart),
		.lbWr (lbWrBus.sink),
		.rdEn (rdEn),
		.rdAddr (rdAddr),
		.rdData (rdData)
	);

	// Priority CPU, then fix, then sprites
	paletteAddressMux #(.LINE_WIDTH(LINE_WIDTH)) paletteAddressMux_inst (
		.CLK_6MB (CLK_6MB),
		.nS1H1 (nS1H1),
		.lineStart (lineStart),
		.fixData (fixData),
		.fixPal (fixPal),
		.cpuPalSel (cpuPalSel),
		.cpuPalAddr (cpuPalAddr),
		.rdEn (rdEn),
		.rdAddr (rdAddr),
		.rdData (rdData),
		.palAddr (palAddr)
	);

	watchdog #(.WD_LIMIT(WD_LIMIT), .WD_PULSE(WD_PULSE)) watchdog_inst (
		.CLK_6MB (CLK_6MB),
		.nS1H1 (nS1H1),
		.wdKick (wdKick),
		.nHalt (nHalt),
		.nReset (nReset)
	);

endmodule

`default_nettype wire

// ==== tests/tbNeoB1.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbNeoB1;
	import neoB1Pkg::*;

	localparam int LINE_WIDTH = 16;
	localparam int WD_LIMIT = 20;
	localparam int WD_PULSE = 4;
	localparam int ADDR_W = $clog2(LINE_WIDTH);
	// Longest wait in clocks for any DUT event
	localparam int WAIT_LIMIT = 200;

	logic CLK_6MB;
	logic nS1H1;
	logic sprValid;
	logic sprReady;
	logic [ADDR_W-1:0] sprX;
	logic [7:0] sprPal;
	logic [31:0] sprGfx;
	logic lineStart;
	logic [7:0] fixData;
	logic [3:0] fixPal;
	logic cpuPalSel;
	palIndexT cpuPalAddr;
	logic wdKick;
	palIndexT palAddr;
	logic nHalt;
	logic nReset;

	// Rising edges seen so far
	// Sampled only on falling edges
	int posCount = 0;
	// Edge count right after the lineStart edge
	int lineEdge = -1000;
	// Edge of the last kick or of reset release
	int refEdge = 0;

	neoB1 #(
		.LINE_WIDTH(LINE_WIDTH),
		.WD_LIMIT(WD_LIMIT),
		.WD_PULSE(WD_PULSE)
	) neoB1_inst (
		.CLK_6MB (CLK_6MB),
		.nS1H1 (nS1H1),
		.sprValid (sprValid),
		.sprReady (sprReady),
		.sprX (sprX),
		.sprPal (sprPal),
		.sprGfx (sprGfx),
		.lineStart (lineStart),
		.fixData (fixData),
		.fixPal (fixPal),
		.cpuPalSel (cpuPalSel),
		.cpuPalAddr (cpuPalAddr),
		.wdKick (wdKick),
		.palAddr (palAddr),
		.nHalt (nHalt),
		.nReset (nReset)
	);

	initial
	begin
		CLK_6MB = 1'b0;
		forever #20 CLK_6MB = ~CLK_6MB;
	end

	always @(posedge CLK_6MB)
		posCount <= posCount + 1;

	task automatic stopWithFailure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "run stopped at first error");
	endtask

	task automatic checkPalAddr(input string name, input palIndexT expected,
		input palIndexT actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Fail %s expected %h actual %h", name, expected, actual));
	endtask

	// Bit 1 is nHalt and bit 0 is nReset
	task automatic checkResetLines(input string name, input logic [1:0] expected,
		input logic [1:0] actual);
		if (actual !== expected)
			stopWithFailure($sformatf("Fail %s expected %b actual %b", name, expected, actual));
	endtask

	// Run to the falling edge after rising edge number target
	task automatic waitForEdgeCount(input int target, input string what);
		int guard;
		guard = 0;
		if (posCount > target)
			stopWithFailure($sformatf("%s was due at an earlier clock edge", what));
		while (posCount < target)
		begin
			@(negedge CLK_6MB);
			guard++;
			if (guard > WAIT_LIMIT)
				stopWithFailure($sformatf("Timed out waiting for %s", what));
		end
	endtask

	task automatic waitForSprReady(input string what);
		int guard;
		guard = 0;
		while (!sprReady)
		begin
			@(negedge CLK_6MB);
			guard++;
			if (guard > WAIT_LIMIT)
				stopWithFailure($sformatf("Timed out waiting for sprReady at %s", what));
		end
	endtask

	task automatic idleGap();
		int n;
		n = int'($urandom_range(2, 0));
		repeat (n) @(negedge CLK_6MB);
	endtask

	// Hand over one strip and wait until all 8 pixels are walked
	task automatic sendStrip(input logic [ADDR_W-1:0] x, input logic [7:0] pal,
		input logic [31:0] gfx);
		waitForSprReady("strip handshake");
		sprX = x;
		sprPal = pal;
		sprGfx = gfx;
		sprValid = 1'b1;
		@(negedge CLK_6MB);
		sprValid = 1'b0;
		// Writer is busy walking the strip
		if (sprReady)
			stopWithFailure("sprReady stayed high after a strip was accepted");
		waitForSprReady("strip completion");
	endtask

	task automatic startLine();
		// Previous scan and its two pipeline stages must drain first
		if (posCount < lineEdge + LINE_WIDTH + 2)
			waitForEdgeCount(lineEdge + LINE_WIDTH + 2, "end of previous line");
		lineStart = 1'b1;
		lineEdge = posCount + 1;
		@(negedge CLK_6MB);
		lineStart = 1'b0;
	endtask

	task automatic kickWatchdog();
		wdKick = 1'b1;
		refEdge = posCount + 1;
		@(negedge CLK_6MB);
		wdKick = 1'b0;
	endtask

	// Pixel x leaves the second stage two clocks after its read
	task automatic checkPixel(input string name, input int x, input palIndexT expected);
		string tag;
		tag = $sformatf("%s x=%0d", name, x);
		waitForEdgeCount(lineEdge + 2 + x, tag);
		checkPalAddr(tag, expected, palAddr);
	endtask

	task automatic checkBlankLine(input string name);
		for (int x = 0; x < LINE_WIDTH; x++)
			checkPixel(name, x, LB_CLEAR);
	endtask

	initial
	begin
		int fd;
		string cmd;
		string name;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [8*128-1:0] restOfLine;

		nS1H1 = 1'b1;
		sprValid = 1'b0;
		sprX = '0;
		sprPal = '0;
		sprGfx = '0;
		lineStart = 1'b0;
		fixData = '0;
		fixPal = '0;
		cpuPalSel = 1'b0;
		cpuPalAddr = '0;
		wdKick = 1'b0;
		void'($urandom(40));

		fd = $fopen("tests/neoB1Stimulus.txt", "r");
		if (fd == 0)
			stopWithFailure("Could not open the stimulus file tests/neoB1Stimulus.txt");

		// Reset spans two rising edges
		repeat (2) @(posedge CLK_6MB);
		@(negedge CLK_6MB);
		nS1H1 = 1'b0;
		refEdge = posCount;

		while ($fscanf(fd, "%s", cmd) == 1)
		begin
			if (cmd.len() > 0 && cmd[0] == "#")
				void'($fgets(restOfLine, fd));
			else if (cmd == "spr")
			begin
				if ($fscanf(fd, "%h %h %h", f1, f2, f3) != 3)
					stopWithFailure("Malformed spr line in the stimulus file");
				idleGap();
				sendStrip(f1[ADDR_W-1:0], f2[7:0], f3);
			end
			else if (cmd == "line")
			begin
				idleGap();
				startLine();
			end
			else if (cmd == "fix")
			begin
				if ($fscanf(fd, "%h %h", f1, f2) != 2)
					stopWithFailure("Malformed fix line in the stimulus file");
				fixData = f1[7:0];
				fixPal = f2[3:0];
			end
			else if (cmd == "cpu")
			begin
				if ($fscanf(fd, "%h %h", f1, f2) != 2)
					stopWithFailure("Malformed cpu line in the stimulus file");
				cpuPalSel = f1[0];
				cpuPalAddr = f2[11:0];
			end
			else if (cmd == "kick")
			begin
				idleGap();
				kickWatchdog();
			end
			else if (cmd == "pix")
			begin
				if ($fscanf(fd, "%s %h %h", name, f1, f2) != 3)
					stopWithFailure("Malformed pix line in the stimulus file");
				checkPixel(name, int'(f1), f2[11:0]);
			end
			else if (cmd == "clear")
			begin
				if ($fscanf(fd, "%s", name) != 1)
					stopWithFailure("Malformed clear line in the stimulus file");
				checkBlankLine(name);
			end
			else if (cmd == "wd")
			begin
				if ($fscanf(fd, "%s %h %h %h", name, f1, f2, f3) != 4)
					stopWithFailure("Malformed wd line in the stimulus file");
				waitForEdgeCount(refEdge + int'(f1), name);
				checkResetLines(name, {f2[0], f3[0]}, {nHalt, nReset});
			end
			else
				stopWithFailure($sformatf("Unknown command %s in the stimulus file", cmd));
		end

		$fclose(fd);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tests/neoB1Stimulus.txt ====
# All numbers hex. spr x pal gfx | line | fix data pal | cpu sel addr | kick
# pix name x expected | clear name | wd name cyclesAfterKick nHalt nReset
wd afterReset 1 1 1
line
clear firstLine
spr 2 12 00003021
spr 5 34 00000054
spr c 56 777000f9
line
pix sprLow 2 121
pix sprHigh 3 122
pix sprTransparent 4 fff
pix sprOverwrite 5 344
pix sprOverwrite 6 345
pix sprEdge c 569
pix sprEdge d 56f
pix sprOffEdge f fff
spr 0 9a 00000011
fix 30 7
line
pix fixEvenSprite 0 9a1
pix fixOdd 1 073
pix fixEvenClear 2 fff
pix fixOdd 3 073
spr 0 9a 00000011
cpu 1 5a5
line
pix cpuOverSprite 0 5a5
pix cpuOverFix 1 5a5
pix cpuOverClear 2 5a5
cpu 0 000
fix 00 0
line
clear afterFixLine
line
clear afterSpriteLine
kick
wd kickedA c 1 1
kick
wd kickedB c 1 1
kick
wd beforeLimit 13 1 1
wd atLimit 14 0 0
wd pulseEnd 17 0 0
wd released 18 1 1

// ==== tb.f ====
src/neoB1Pkg.sv
src/lineBufferWriteIf.sv
src/spritePixelWriter.sv
src/lineBuffer.sv
src/paletteAddressMux.sv
src/watchdog.sv
src/neoB1.sv
tests/tbNeoB1.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the neoB1 testbench with Verilator from the project root

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
	echo "Cannot enter the project root"
	exit 1
fi

verilator --binary --timing -f tb.f --top-module tbNeoB1 -o simNeoB1
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/simNeoB1
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation failed with status $status"
	exit $status
fi
exit 0
